// File: files.f
+incdir+include
source/mem_pkg.sv
source/ram_sdp.sv
source/io_read_select.sv
source/io_write_ports.sv
source/data_memory.sv
source/host_bus_adapter.sv
source/memory_subsystem_top.sv
test/memory_subsystem_assert.sv
test/memory_subsystem_tb.sv

// File: include/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// ---------------------------------------------------------------------------
// Data path and address space sizes.
// ---------------------------------------------------------------------------

`define MEM_WORD_WIDTH      32
`define MEM_ADDR_WIDTH      8
`define MEM_DEPTH           256

// The I/O window sits at the top of the address space, above the RAM words
// that software normally uses. Address zero must never fall inside it.
`define MEM_IO_PORT_COUNT   4
`define MEM_IO_BASE_ADDR    240
`define MEM_IO_ADDR_WIDTH   2

// Pipeline depth of the data memory as seen from the bus adapter.
`define MEM_WRITE_LATENCY   2
`define MEM_READ_LATENCY    2

`endif

// File: run_sim.sh
#!/bin/sh
# Builds the memory subsystem testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f \
    --top-module memory_subsystem_tb -o memory_subsystem_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/memory_subsystem_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q '^All checks passed$'; then
    exit 0
fi
exit 1

// File: source/data_memory.sv
`timescale 1ns/1ns
`default_nettype none

// Data memory for the processor's load/store path. A RAM and a bank of
// memory-mapped I/O ports share one word address space.
// Address zero always reads as zero and is never written; the RAM is not
// even enabled for it. Addresses flagged as I/O never touch the RAM.
// Reads and writes are both two-stage pipelines and each can accept a new
// access every cycle.
module data_memory import mem_pkg::*; (
    input  wire logic      clock,
    input  wire logic      rst_n,

    input  wire logic      read_enable,
    input  wire addr_t     read_addr,
    input  wire logic      read_addr_is_io,
    output word_t          read_data,
    input  wire io_words_t io_read_data,

    input  wire logic      write_enable,
    input  wire addr_t     write_addr,
    input  wire logic      write_addr_is_io,
    input  wire word_t     write_data,
    output io_mask_t       io_wren,
    output io_words_t      io_write_data
);

    // ------------------------------------------------------------------------
    // RAM. It is read in read stage 1 and written in write stage 2.
    // ------------------------------------------------------------------------

    word_t mem_read_data;
    logic  mem_rden;
    logic  mem_wren;
    logic  write_enable_stage2;
    logic  write_is_io_stage2;
    addr_t write_addr_stage2;
    word_t write_data_stage2;

    ram_sdp MEM (
        .clock      (clock),
        .rst_n      (rst_n),
        .wren       (mem_wren),
        .write_addr (write_addr_stage2),
        .write_data (write_data_stage2),
        .rden       (mem_rden),
        .read_addr  (read_addr),
        .read_data  (mem_read_data)
    );

    // ------------------------------------------------------------------------
    // Read stage 1.
    // ------------------------------------------------------------------------

    word_t io_word_raw;
    word_t io_word_stage2;
    logic  read_is_io_stage2;
    logic  read_is_zero_stage2;

    io_read_select io_read_sel (
        .addr         (read_addr),
        .io_read_data (io_read_data),
        .data         (io_word_raw)
    );

    // The RAM stays idle for I/O reads and for reads of address zero.
    always_comb begin
        mem_rden = read_enable && !read_addr_is_io && (read_addr != '0);
    end

    // The addressed I/O word is captured for read stage 2.
    always_ff @(posedge clock) begin
        io_word_stage2 <= io_word_raw;
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            read_is_io_stage2   <= 1'b0;
            read_is_zero_stage2 <= 1'b0;
        end else begin
            read_is_io_stage2   <= read_addr_is_io;
            read_is_zero_stage2 <= (read_addr == '0);
        end
    end

    // ------------------------------------------------------------------------
    // Read stage 2.
    // ------------------------------------------------------------------------

    // Address zero is forced to zero here rather than relying on whatever
    // the idle RAM output happens to hold.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            read_data <= '0;
        end else if (read_is_zero_stage2) begin
            read_data <= '0;
        end else begin
            read_data <= read_is_io_stage2 ? io_word_stage2 : mem_read_data;
        end
    end

    // ------------------------------------------------------------------------
    // Write stage 1. The whole write is carried into stage 2.
    // ------------------------------------------------------------------------

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            write_enable_stage2 <= 1'b0;
            write_is_io_stage2  <= 1'b0;
        end else begin
            write_enable_stage2 <= write_enable;
            write_is_io_stage2  <= write_addr_is_io;
        end
    end

    always_ff @(posedge clock) begin
        write_addr_stage2 <= write_addr;
        write_data_stage2 <= write_data;
    end

    // ------------------------------------------------------------------------
    // Write stage 2.
    // ------------------------------------------------------------------------

    io_mask_t port_wren;
    logic     io_write_enable;

    // Writes to I/O or to address zero never reach the RAM.
    always_comb begin
        mem_wren = write_enable_stage2 && !write_is_io_stage2 &&
                   (write_addr_stage2 != '0);
        io_write_enable = write_enable_stage2 && write_is_io_stage2;
    end

    io_write_ports io_write (
        .clock         (clock),
        .rst_n         (rst_n),
        .enable        (io_write_enable),
        .addr          (write_addr_stage2),
        .write_data    (write_data_stage2),
        .port_wren     (port_wren),
        .io_write_data (io_write_data)
    );

    // The strobe lags the port data by one cycle, so it is seen only once
    // the new word is already stable on io_write_data.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            io_wren <= '0;
        end else begin
            io_wren <= port_wren;
        end
    end

endmodule

`default_nettype wire

// File: source/host_bus_adapter.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_config.svh"

// Bridges the host's four-phase req/ack bus to the one-cycle enables of the
// pipelined data memory. Only one host access is ever in flight.
module host_bus_adapter import mem_pkg::*; (
    input  wire logic    clock,
    input  wire logic    rst_n,

    input  wire logic    req,
    input  wire bus_op_e op,
    input  wire addr_t   addr,
    input  wire word_t   wdata,
    output logic         ack,
    output word_t        rdata,

    output logic         read_enable,
    output addr_t        read_addr,
    output logic         read_addr_is_io,
    input  wire word_t   read_data,
    output logic         write_enable,
    output addr_t        write_addr,
    output logic         write_addr_is_io,
    output word_t        write_data
);

    // ------------------------------------------------------------------------
    // Address window and latency constants.
    // ------------------------------------------------------------------------

    localparam addr_t IO_FIRST = addr_t'(`MEM_IO_BASE_ADDR);
    localparam addr_t IO_LAST  = addr_t'(`MEM_IO_BASE_ADDR + `MEM_IO_PORT_COUNT - 1);
    localparam int MAX_LATENCY = (`MEM_READ_LATENCY > `MEM_WRITE_LATENCY) ?
                                 `MEM_READ_LATENCY : `MEM_WRITE_LATENCY;
    localparam int WAIT_WIDTH  = $clog2(MAX_LATENCY + 1);

    typedef logic [WAIT_WIDTH-1:0] wait_count_t;

    adapter_state_e state;
    wait_count_t    wait_count;
    logic           addr_is_io;

    // The host holds addr and wdata stable for the whole access.
    always_comb begin
        addr_is_io       = (addr >= IO_FIRST) && (addr <= IO_LAST);
        read_addr        = addr;
        read_addr_is_io  = addr_is_io;
        write_addr       = addr;
        write_addr_is_io = addr_is_io;
        write_data       = wdata;
    end

    // Each enable is high for the single ISSUE cycle of its access.
    always_comb begin
        read_enable  = (state == ST_ISSUE) && (op == OP_READ);
        write_enable = (state == ST_ISSUE) && (op == OP_WRITE);
    end

    // ------------------------------------------------------------------------
    // Handshake FSM.
    // ------------------------------------------------------------------------

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            wait_count <= '0;
            ack        <= 1'b0;
            rdata      <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        state <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    // Count down to the last cycle of the memory latency.
                    wait_count <= (op == OP_READ) ?
                                  wait_count_t'(`MEM_READ_LATENCY - 1) :
                                  wait_count_t'(`MEM_WRITE_LATENCY - 1);
                    state      <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (wait_count == '0) begin
                        if (op == OP_READ) begin
                            rdata <= read_data;
                        end
                        state <= ST_ACK;
                    end else begin
                        wait_count <= wait_count - 1'b1;
                    end
                end
                ST_ACK: begin
                    // Hold ack for as long as the host keeps req high.
                    if (req) begin
                        ack <= 1'b1;
                    end else begin
                        ack   <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/io_read_select.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_config.svh"

// Picks one I/O input word by address. The address is made relative to the
// start of the I/O window and its low bits become the port index.
// Whether the address is really inside the window is decided upstream,
// in the bus adapter, so no range check is made here.
module io_read_select import mem_pkg::*; (
    input  wire addr_t     addr,
    input  wire io_words_t io_read_data,
    output word_t          data
);

    addr_t                        offset;
    logic [`MEM_IO_ADDR_WIDTH-1:0] port_index;

    // Translate the global word address into an offset within the window.
    always_comb begin
        offset = addr - addr_t'(`MEM_IO_BASE_ADDR);
    end

    // Out-of-window addresses simply alias onto some port.
    always_comb begin
        port_index = offset[`MEM_IO_ADDR_WIDTH-1:0];
    end

    always_comb begin
        data = io_read_data[port_index];
    end

endmodule

`default_nettype wire

// File: source/io_write_ports.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_config.svh"

// Bank of output port registers. A write lands in the one port selected by
// the translated address; the other ports keep their words. The one-hot
// write mask is registered alongside so that downstream logic can tell
// which port just changed.
module io_write_ports import mem_pkg::*; (
    input  wire logic  clock,
    input  wire logic  rst_n,
    input  wire logic  enable,
    input  wire addr_t addr,
    input  wire word_t write_data,
    output io_mask_t   port_wren,
    output io_words_t  io_write_data
);

    addr_t                        offset;
    logic [`MEM_IO_ADDR_WIDTH-1:0] port_index;
    io_mask_t                     port_mask;

    // ------------------------------------------------------------------------
    // Address decode.
    // ------------------------------------------------------------------------

    always_comb begin
        offset     = addr - addr_t'(`MEM_IO_BASE_ADDR);
        port_index = offset[`MEM_IO_ADDR_WIDTH-1:0];
    end

    // One-hot when enabled, all zero otherwise.
    always_comb begin
        port_mask = enable ? (io_mask_t'(1) << port_index) : '0;
    end

    // ------------------------------------------------------------------------
    // Port registers.
    // ------------------------------------------------------------------------

    // The mask is reloaded every cycle, so a write shows for one cycle only.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            port_wren     <= '0;
            io_write_data <= '0;
        end else begin
            port_wren <= port_mask;
            if (enable) begin
                io_write_data[port_index] <= write_data;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/mem_pkg.sv
`default_nettype none

`include "mem_config.svh"

package mem_pkg;

    // One data word and one word address.
    typedef logic [`MEM_WORD_WIDTH-1:0] word_t;
    typedef logic [`MEM_ADDR_WIDTH-1:0] addr_t;

    // One bit per I/O port, and all port words with port 0 in the low word.
    typedef logic [`MEM_IO_PORT_COUNT-1:0] io_mask_t;
    typedef word_t [`MEM_IO_PORT_COUNT-1:0] io_words_t;

    // Host side opcode.
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_e;

    // Bus adapter handshake states.
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_ISSUE = 2'd1,
        ST_WAIT  = 2'd2,
        ST_ACK   = 2'd3
    } adapter_state_e;

endpackage

`default_nettype wire

// File: source/memory_subsystem_top.sv
`timescale 1ns/1ns
`default_nettype none

// Host bus adapter in front of the data memory.
module memory_subsystem_top import mem_pkg::*; (
    input  wire logic      clock,
    input  wire logic      rst_n,
    input  wire logic      req,
    input  wire bus_op_e   op,
    input  wire addr_t     addr,
    input  wire word_t     wdata,
    output logic           ack,
    output word_t          rdata,
    input  wire io_words_t io_read_data,
    output io_words_t      io_write_data,
    output io_mask_t       io_wren
);

    logic  read_enable;
    addr_t read_addr;
    logic  read_addr_is_io;
    word_t read_data;
    logic  write_enable;
    addr_t write_addr;
    logic  write_addr_is_io;
    word_t write_data;

    host_bus_adapter adapter (
        .clock            (clock),
        .rst_n            (rst_n),
        .req              (req),
        .op               (op),
        .addr             (addr),
        .wdata            (wdata),
        .ack              (ack),
        .rdata            (rdata),
        .read_enable      (read_enable),
        .read_addr        (read_addr),
        .read_addr_is_io  (read_addr_is_io),
        .read_data        (read_data),
        .write_enable     (write_enable),
        .write_addr       (write_addr),
        .write_addr_is_io (write_addr_is_io),
        .write_data       (write_data)
    );

    data_memory memory (
        .clock            (clock),
        .rst_n            (rst_n),
        .read_enable      (read_enable),
        .read_addr        (read_addr),
        .read_addr_is_io  (read_addr_is_io),
        .read_data        (read_data),
        .io_read_data     (io_read_data),
        .write_enable     (write_enable),
        .write_addr       (write_addr),
        .write_addr_is_io (write_addr_is_io),
        .write_data       (write_data),
        .io_wren          (io_wren),
        .io_write_data    (io_write_data)
    );

endmodule

`default_nettype wire

// File: source/ram_sdp.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_config.svh"

// Simple dual-port RAM. One write port and one read port, both synchronous.
// The read port has an output register that holds its value when rden is low.
module ram_sdp import mem_pkg::*; (
    input  wire logic  clock,
    input  wire logic  rst_n,
    input  wire logic  wren,
    input  wire addr_t write_addr,
    input  wire word_t write_data,
    input  wire logic  rden,
    input  wire addr_t read_addr,
    output word_t      read_data
);

    word_t mem [`MEM_DEPTH];

    // The array powers up cleared, so untouched words read back as zero.
    initial begin
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clock) begin
        if (wren) begin
            mem[write_addr] <= write_data;
        end
    end

    // Only the output register is cleared by reset.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            read_data <= '0;
        end else if (rden) begin
            read_data <= mem[read_addr];
        end
    end

endmodule

`default_nettype wire

// File: test/memory_subsystem_assert.sv
`timescale 1ns/1ns
`default_nettype none

// Protocol checks for the host handshake and the I/O write strobe. The same
// module is bound into the adapter and into the data memory; each binding
// ties off the ports that its target does not have.
module memory_subsystem_assert import mem_pkg::*; (
    input  wire logic     clock,
    input  wire logic     rst_n,
    input  wire logic     req,
    input  wire logic     ack,
    input  wire io_mask_t io_wren
);

    // ack is only raised in answer to a pending request.
    ack_rises_with_req: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
        else $error("ack rose while req was low");

    // ack stays up until the host has withdrawn its request.
    ack_falls_after_req: assert property (@(posedge clock) disable iff (!rst_n)
        $fell(ack) |-> !$past(req))
        else $error("ack fell while req was still high");

    // At most one port is strobed, and never for two cycles in a row.
    io_wren_onehot: assert property (@(posedge clock) disable iff (!rst_n)
        $onehot0(io_wren))
        else $error("io_wren has more than one bit set");

    io_wren_one_cycle: assert property (@(posedge clock) disable iff (!rst_n)
        (io_wren != '0) |=> (io_wren == '0))
        else $error("io_wren stayed set for more than one cycle");

endmodule

bind host_bus_adapter memory_subsystem_assert handshake_checks (
    .clock   (clock),
    .rst_n   (rst_n),
    .req     (req),
    .ack     (ack),
    .io_wren ('0)
);

bind data_memory memory_subsystem_assert io_wren_checks (
    .clock   (clock),
    .rst_n   (rst_n),
    .req     (1'b0),
    .ack     (1'b0),
    .io_wren (io_wren)
);

`default_nettype wire

// File: test/memory_subsystem_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_config.svh"

module memory_subsystem_tb import mem_pkg::*; ();

    localparam int CLOCK_PERIOD      = 4;
    localparam int RESET_CYCLES      = 10;
    localparam int RANDOM_ACCESSES   = 40;
    localparam int CYCLES_PER_ACCESS = 50;

    // One host access together with the io_read_data words driven during it.
    typedef struct packed {
        bus_op_e   op;
        addr_t     addr;
        word_t     wdata;
        io_words_t io_in;
        word_t     expected;
    } access_t;

    logic      clock;
    logic      rst_n;
    logic      req;
    bus_op_e   op;
    addr_t     addr;
    word_t     wdata;
    logic      ack;
    word_t     rdata;
    io_words_t io_read_data;
    io_words_t io_write_data;
    io_mask_t  io_wren;

    access_t   file_accesses[$];
    word_t     ram_model [`MEM_DEPTH];
    io_words_t port_model;
    int        access_total;
    int        seed;
    int        enable_cycles;
    int        wren_cycles;

    memory_subsystem_top UUT (
        .clock         (clock),
        .rst_n         (rst_n),
        .req           (req),
        .op            (op),
        .addr          (addr),
        .wdata         (wdata),
        .ack           (ack),
        .rdata         (rdata),
        .io_read_data  (io_read_data),
        .io_write_data (io_write_data),
        .io_wren       (io_wren)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    // -------------------------------------------------------------------------
    // Compare tasks.
    // -------------------------------------------------------------------------

    task automatic stop_on_failure();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_word(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_ports(string name, io_words_t expected, io_words_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_mask(string name, io_mask_t expected, io_mask_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s expected %b actual %b", $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s expected %b actual %b", $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    // -------------------------------------------------------------------------
    // Reference model of the address map.
    // -------------------------------------------------------------------------

    // The I/O window is the port count of words starting at the base address.
    function automatic logic is_io_addr(addr_t a);
        return (int'(a) >= `MEM_IO_BASE_ADDR) &&
               (int'(a) < `MEM_IO_BASE_ADDR + `MEM_IO_PORT_COUNT);
    endfunction

    function automatic int port_of(addr_t a);
        return int'(a) - `MEM_IO_BASE_ADDR;
    endfunction

    // Only a write into the window strobes a port.
    function automatic io_mask_t expected_mask(access_t acc);
        if (acc.op == OP_WRITE && is_io_addr(acc.addr)) begin
            return io_mask_t'(1) << port_of(acc.addr);
        end
        return '0;
    endfunction

    // Address zero is never written, and I/O writes never land in the RAM.
    function automatic void apply_to_model(access_t acc);
        if (acc.op == OP_WRITE) begin
            if (is_io_addr(acc.addr)) begin
                port_model[port_of(acc.addr)] = acc.wdata;
            end else if (acc.addr != '0) begin
                ram_model[acc.addr] = acc.wdata;
            end
        end
    endfunction

    // -------------------------------------------------------------------------
    // Stimulus.
    // -------------------------------------------------------------------------

    task automatic load_tests();
        int         fd;
        int         fields;
        string      line;
        logic [3:0] op_value;
        addr_t      a;
        word_t      d;
        word_t      io0;
        word_t      io1;
        word_t      io2;
        word_t      io3;
        word_t      expected;
        access_t    acc;
        fd = $fopen("test/memory_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/memory_tests.txt");
            stop_on_failure();
        end
        // Comment lines do not scan as numbers and drop out here.
        while (!$feof(fd)) begin
            if ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                 op_value, a, d, io0, io1, io2, io3, expected);
                if (fields == 8) begin
                    acc.op       = op_value[0] ? OP_WRITE : OP_READ;
                    acc.addr     = a;
                    acc.wdata    = d;
                    acc.io_in    = {io3, io2, io1, io0};
                    acc.expected = expected;
                    file_accesses.push_back(acc);
                end
            end
        end
        $fclose(fd);
    endtask

    // One clock of an access. Enables are counted to catch a repeated issue,
    // and every strobe seen on io_wren must match the access's port.
    task automatic sample_cycle(access_t acc);
        @(posedge clock);
        if (UUT.read_enable || UUT.write_enable) begin
            enable_cycles++;
        end
        if (io_wren != '0) begin
            wren_cycles++;
            check_mask("io_wren", expected_mask(acc), io_wren);
        end
    endtask

    // Full four-phase handshake. The host keeps req up for hold_cycles
    // extra clocks after ack to exercise back-pressure.
    task automatic run_access(access_t acc, int hold_cycles);
        int expected_wren;
        enable_cycles = 0;
        wren_cycles   = 0;
        req          <= 1'b1;
        op           <= acc.op;
        addr         <= acc.addr;
        wdata        <= acc.wdata;
        io_read_data <= acc.io_in;
        do begin
            sample_cycle(acc);
        end while (!ack);
        repeat (hold_cycles) begin
            sample_cycle(acc);
            check_flag("ack", 1'b1, ack);
        end
        req <= 1'b0;
        do begin
            sample_cycle(acc);
        end while (ack);
        apply_to_model(acc);
        expected_wren = (expected_mask(acc) != '0) ? 1 : 0;
        if (enable_cycles != 1) begin
            $display("Access to address %h issued %0d memory enables instead of one",
                     acc.addr, enable_cycles);
            stop_on_failure();
        end
        if (wren_cycles != expected_wren) begin
            $display("io_wren was set for %0d cycles during the access to %h, expected %0d",
                     wren_cycles, acc.addr, expected_wren);
            stop_on_failure();
        end
        if (acc.op == OP_READ) begin
            check_word("rdata", acc.expected, rdata);
        end
        check_ports("io_write_data", port_model, io_write_data);
    endtask

    // -------------------------------------------------------------------------
    // Main sequence and watchdog.
    // -------------------------------------------------------------------------

    initial begin
        access_t acc;
        clock        = 1'b0;
        rst_n        = 1'b0;
        req          = 1'b0;
        op           = OP_READ;
        addr         = '0;
        wdata        = '0;
        io_read_data = '0;
        seed         = 32'h03f20f48;
        access_total = 0;
        port_model   = '0;
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            ram_model[i] = '0;
        end
        load_tests();
        access_total = file_accesses.size() + RANDOM_ACCESSES;

        repeat (RESET_CYCLES) @(posedge clock);
        rst_n <= 1'b1;
        @(posedge clock);
        check_flag("ack", 1'b0, ack);
        check_mask("io_wren", '0, io_wren);
        check_word("rdata", '0, rdata);
        check_ports("io_write_data", '0, io_write_data);

        foreach (file_accesses[i]) begin
            run_access(file_accesses[i], i % 3);
        end

        // Random traffic stays below the I/O window, so the RAM model alone
        // predicts every read.
        for (int i = 0; i < RANDOM_ACCESSES; i++) begin
            acc.op       = (($random(seed) & 1) != 0) ? OP_WRITE : OP_READ;
            acc.addr     = addr_t'($unsigned($random(seed)) % `MEM_IO_BASE_ADDR);
            acc.wdata    = $random(seed);
            acc.io_in    = '0;
            acc.expected = (acc.op == OP_READ) ? ram_model[acc.addr] : '0;
            run_access(acc, i % 3);
        end

        $display("All checks passed");
        $finish;
    end

    initial begin
        wait (access_total > 0);
        repeat (access_total * CYCLES_PER_ACCESS) @(posedge clock);
        $display("Timeout: the accesses did not finish within %0d clock cycles",
                 access_total * CYCLES_PER_ACCESS);
        stop_on_failure();
    end

endmodule

`default_nettype wire

// File: test/memory_tests.txt
# op addr wdata io_port0 io_port1 io_port2 io_port3 expected_rdata (all hex)
# op is 0 for a read and 1 for a write. expected_rdata is compared for reads only.
0 05 00000000 a0a0a0a0 a1a1a1a1 a2a2a2a2 a3a3a3a3 00000000
1 05 deadbeef a0a0a0a0 a1a1a1a1 a2a2a2a2 a3a3a3a3 00000000
0 05 00000000 a0a0a0a0 a1a1a1a1 a2a2a2a2 a3a3a3a3 deadbeef
1 00 12345678 a0a0a0a0 a1a1a1a1 a2a2a2a2 a3a3a3a3 00000000
0 00 00000000 a0a0a0a0 a1a1a1a1 a2a2a2a2 a3a3a3a3 00000000
1 0a cafef00d a0a0a0a0 a1a1a1a1 a2a2a2a2 a3a3a3a3 00000000
0 0a 00000000 a0a0a0a0 a1a1a1a1 a2a2a2a2 a3a3a3a3 cafef00d
1 f1 11112222 a0a0a0a0 a1a1a1a1 a2a2a2a2 a3a3a3a3 00000000
0 01 00000000 a0a0a0a0 a1a1a1a1 a2a2a2a2 a3a3a3a3 00000000
0 f1 00000000 5a5a0000 5a5a0001 5a5a0002 5a5a0003 5a5a0001
1 f3 33334444 5a5a0000 5a5a0001 5a5a0002 5a5a0003 00000000
0 03 00000000 5a5a0000 5a5a0001 5a5a0002 5a5a0003 00000000
0 f3 00000000 5a5a0000 5a5a0001 5a5a0002 5a5a0003 5a5a0003
0 f0 00000000 10000000 20000000 30000000 40000000 10000000
0 f2 00000000 10000000 20000000 30000000 40000000 30000000
1 f0 0f0f0f0f 10000000 20000000 30000000 40000000 00000000
1 f2 f0f0f0f0 10000000 20000000 30000000 40000000 00000000
1 ef 77778888 10000000 20000000 30000000 40000000 00000000
0 ef 00000000 10000000 20000000 30000000 40000000 77778888
0 0a 00000000 10000000 20000000 30000000 40000000 cafef00d
